//--- files.f
+incdir+.
tft_pkg.sv
touch_pkg.sv
touch_ctrl.sv
touch_spi.sv
tft_timing.sv
cursor_render.sv
touch_display_top.sv
tb_touch_adc_model.sv
tb_touch_display.sv

//--- Bender.yml
package:
  name: touch_display

export_include_dirs:
  - .

sources:
  - tft_pkg.sv
  - touch_pkg.sv
  - touch_ctrl.sv
  - touch_spi.sv
  - tft_timing.sv
  - cursor_render.sv
  - touch_display_top.sv
  - target: test
    files:
      - tb_touch_adc_model.sv
      - tb_touch_display.sv

//--- tb_touch_display.sv
`timescale 1ns/1ns
`include "display_defs.svh"

module tb_touch_display;
	import tft_pkg::*;

	localparam int H_ACTIVE = 16;
	localparam int H_BLANK = 4;
	localparam int V_ACTIVE = 8;
	localparam int V_BLANK = 2;
	localparam int PIX_DIV = 2;
	localparam int NUM_TESTS = 6;
	// 20 x 10 pixels of 2 cycles each
	localparam int FRAME_CYCLES = (H_ACTIVE + H_BLANK) * (V_ACTIVE + V_BLANK) * PIX_DIV;
	// one conversion is 25 serial clocks of 50 cycles
	// a set of three takes about 11 frames
	// and a touch test waits through up to three sets
	localparam int FRAMES_PER_TEST = 40;
	localparam int CYCLE_LIMIT = (NUM_TESTS * FRAMES_PER_TEST + 20) * FRAME_CYCLES;
	localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;

	logic cclk, rst_n;
	logic [7:0] s_awaddr, s_araddr;
	logic s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready;
	logic s_awready, s_wready, s_bvalid, s_arready, s_rvalid;
	logic [31:0] s_wdata, s_rdata;
	logic [3:0] s_wstrb;
	logic [1:0] s_bresp, s_rresp;
	logic touch_busy, touch_data_out, touch_csb, touch_clk, touch_data_in;
	logic tft_backlight, tft_display, tft_vdd, tft_data_ena;
	logic [7:0] tft_red, tft_green, tft_blue;
	logic [11:0] z_val, x_val, y_val;
	logic [3:0] busy_clocks;

	logic [31:0] rng_state = 32'd69;
	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;
	// expected screen content for the pixel compare
	logic [9:0] exp_cx = '0;
	logic [8:0] exp_cy = '0;
	logic [23:0] exp_bg = '0;
	logic [23:0] exp_cc = '0;
	logic check_on = 1'b0;
	logic frame_seen = 1'b0;
	int pix_checked = 0;
	int low_cnt = 0;
	int run_cnt = 0;
	int row = 0;

	touch_display_top #(
		.H_ACTIVE(H_ACTIVE), .H_BLANK(H_BLANK),
		.V_ACTIVE(V_ACTIVE), .V_BLANK(V_BLANK), .PIX_DIV(PIX_DIV)
	) touch_display_top_inst (.*);

	tb_touch_adc_model tb_touch_adc_model_inst (.*);

	initial begin
		cclk = 1'b0;
		forever #4 cclk = ~cclk;
	end

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// crosshair row or column shows the cursor colour
	function automatic logic [23:0] expected_rgb(input int px, py, input logic [9:0] cx,
		input logic [8:0] cy, input logic [23:0] bg, cc);
		if (px == cx || py == cy)
			return cc;
		return bg;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got, exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	// aw and w together then b after a random host delay
	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		@(negedge cclk);
		s_awaddr = addr;
		s_wdata = data;
		s_wstrb = 4'hF;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		@(negedge cclk);
		while (!s_awready)
			@(negedge cclk);
		@(negedge cclk);
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		while (!s_bvalid)
			@(negedge cclk);
		resp = s_bresp;
		repeat (next_random() % 4)
			@(negedge cclk);
		s_bready = 1'b1;
		@(negedge cclk);
		s_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(negedge cclk);
		s_araddr = addr;
		s_arvalid = 1'b1;
		@(negedge cclk);
		while (!s_arready)
			@(negedge cclk);
		@(negedge cclk);
		s_arvalid = 1'b0;
		while (!s_rvalid)
			@(negedge cclk);
		data = s_rdata;
		resp = s_rresp;
		repeat (next_random() % 4)
			@(negedge cclk);
		s_rready = 1'b1;
		@(negedge cclk);
		s_rready = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
		input logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		compare_value("s_bresp", resp, exp_resp);
	endtask

	task automatic read_expect(input string name, input logic [7:0] addr,
		input logic [31:0] exp);
		logic [31:0] rd;
		logic [1:0] resp;
		axi_read(addr, rd, resp);
		compare_value("s_rresp", resp, OKAY);
		compare_value(name, rd, exp);
	endtask

	// busy bit in STATUS rises and falls once per set
	task automatic wait_sample_sets(input int n);
		logic [31:0] st;
		logic [1:0] resp;
		repeat (n) begin
			do axi_read(`REG_STATUS, st, resp); while (!st[1]);
			do axi_read(`REG_STATUS, st, resp); while (st[1]);
		end
	endtask

	task automatic report_test(input int num, input string name, input int start_err);
		$display("test %0d %s: %s, %0d errors", num, name,
			(errors == start_err) ? "pass" : "fail", errors - start_err);
	endtask

	// raster position rebuilt from tft_data_ena
	// a long low gap marks the vertical blank
	always @(negedge cclk) begin
		if (!tft_data_ena) begin
			low_cnt++;
			run_cnt = 0;
		end else begin
			if (run_cnt == 0) begin
				row = (low_cnt > H_BLANK * PIX_DIV) ? 0 : row + 1;
				if (row == 0 && check_on)
					frame_seen = 1'b1;
				low_cnt = 0;
			end
			// each pixel is held PIX_DIV cycles and looked at once
			if (frame_seen && pix_checked < FRAME_PIXELS && run_cnt % PIX_DIV == 0) begin
				checks++;
				if ({tft_red, tft_green, tft_blue} !== expected_rgb(run_cnt / PIX_DIV, row,
					exp_cx, exp_cy, exp_bg, exp_cc)) begin
					$display("CHECK FAILED tft_rgb at x %0d y %0d got 0x%06h expected 0x%06h",
						run_cnt / PIX_DIV, row, {tft_red, tft_green, tft_blue},
						expected_rgb(run_cnt / PIX_DIV, row, exp_cx, exp_cy, exp_bg, exp_cc));
					errors++;
				end
				pix_checked++;
			end
			run_cnt++;
		end
	end

	// run limit from the test lengths
	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge cclk);
			cycle_cnt++;
		end
		$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Errors found");
		$finish;
	end

	initial begin
		logic [31:0] rd, bg, cc, zmin, touch_exp;
		logic [1:0] resp;
		int start_err, f0, f1;
		s_awaddr = '0;
		s_araddr = '0;
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		s_wdata = '0;
		s_wstrb = '0;
		z_val = '0;
		x_val = '0;
		y_val = '0;
		busy_clocks = '0;
		rst_n = 1'b0;
		repeat (8) @(negedge cclk);
		rst_n = 1'b1;
		@(negedge cclk);

		// reset levels then read back of the writable registers
		start_err = errors;
		compare_value("backlight display vdd data_ena csb",
			{27'b0, tft_backlight, tft_display, tft_vdd, tft_data_ena, touch_csb}, 32'h1);
		write_reg(`REG_CTRL, 32'h1, OKAY);
		read_expect("CTRL", `REG_CTRL, 32'h1);
		bg = next_random();
		write_reg(`REG_BG, bg, OKAY);
		read_expect("BG", `REG_BG, bg & 32'hFF_FFFF);
		cc = next_random();
		write_reg(`REG_CURSOR_COLOR, cc, OKAY);
		read_expect("CURSOR_COLOR", `REG_CURSOR_COLOR, cc & 32'hFF_FFFF);
		zmin = next_random();
		write_reg(`REG_Z_MIN, zmin, OKAY);
		read_expect("Z_MIN", `REG_Z_MIN, zmin & 32'hFFF);
		report_test(1, "reset and register read back", start_err);

		// holes and read-only registers
		start_err = errors;
		axi_read(8'h18, rd, resp);
		compare_value("s_rresp", resp, SLVERR);
		write_reg(8'h20, 32'hFFFF_FFFF, SLVERR);
		write_reg(`REG_TOUCH, 32'hFFFF_FFFF, SLVERR);
		write_reg(`REG_STATUS, 32'hFFFF_FFFF, SLVERR);
		read_expect("CTRL", `REG_CTRL, 32'h1);
		read_expect("BG", `REG_BG, bg & 32'hFF_FFFF);
		read_expect("CURSOR_COLOR", `REG_CURSOR_COLOR, cc & 32'hFF_FFFF);
		read_expect("Z_MIN", `REG_Z_MIN, zmin & 32'hFFF);
		read_expect("TOUCH", `REG_TOUCH, 32'h0);
		report_test(2, "error responses", start_err);

		// pressure at or above threshold
		start_err = errors;
		zmin = 32'h100 + next_random() % 32'h400;
		z_val = 12'(zmin + next_random() % 32'h100);
		x_val = 12'(next_random());
		y_val = 12'(next_random());
		busy_clocks = 4'(next_random() % 4);
		write_reg(`REG_Z_MIN, zmin, OKAY);
		write_reg(`REG_CTRL, 32'h2, OKAY);
		wait_sample_sets(1);
		touch_exp = {7'b0, 9'(y_val >> `TOUCH_SHIFT), 6'b0, 10'(x_val >> `TOUCH_SHIFT)};
		read_expect("TOUCH", `REG_TOUCH, touch_exp);
		axi_read(`REG_STATUS, rd, resp);
		compare_value("STATUS pen_down", rd[0], 32'h1);
		report_test(3, "touch above threshold", start_err);

		// light press with model values changed only between sets
		start_err = errors;
		wait_sample_sets(1);
		z_val = 12'(zmin - 1 - next_random() % 32'h80);
		x_val = ~x_val;
		y_val = ~y_val;
		wait_sample_sets(1);
		read_expect("TOUCH", `REG_TOUCH, touch_exp);
		axi_read(`REG_STATUS, rd, resp);
		compare_value("STATUS pen_down", rd[0], 32'h0);
		report_test(4, "touch below threshold", start_err);

		// full frame against the reference with the cursor kept on screen
		start_err = errors;
		wait_sample_sets(1);
		z_val = 12'(zmin + next_random() % 32'h100);
		x_val = 12'(next_random() % (H_ACTIVE << `TOUCH_SHIFT));
		y_val = 12'(next_random() % (V_ACTIVE << `TOUCH_SHIFT));
		busy_clocks = 4'(next_random() % 4);
		bg = next_random();
		cc = next_random();
		write_reg(`REG_BG, bg, OKAY);
		write_reg(`REG_CURSOR_COLOR, cc, OKAY);
		write_reg(`REG_CTRL, 32'h3, OKAY);
		exp_bg = bg[23:0];
		exp_cc = cc[23:0];
		exp_cx = 10'(x_val >> `TOUCH_SHIFT);
		exp_cy = 9'(y_val >> `TOUCH_SHIFT);
		wait_sample_sets(1);
		read_expect("TOUCH", `REG_TOUCH, {7'b0, exp_cy, 6'b0, exp_cx});
		check_on = 1'b1;
		wait (pix_checked == FRAME_PIXELS);
		@(negedge cclk);
		check_on = 1'b0;
		report_test(5, "full frame render", start_err);

		// panel off while the frame counter still runs
		start_err = errors;
		// power pins are up while the enable bit is set
		compare_value("backlight display vdd",
			{29'b0, tft_backlight, tft_display, tft_vdd}, 32'h7);
		write_reg(`REG_CTRL, 32'h0, OKAY);
		axi_read(`REG_STATUS, rd, resp);
		f0 = rd[15:8];
		do begin
			axi_read(`REG_STATUS, rd, resp);
			compare_value("backlight display vdd data_ena",
				{28'b0, tft_backlight, tft_display, tft_vdd, tft_data_ena}, 32'h0);
			f1 = 8'(rd[15:8] - f0);
		end while (f1 < 2);
		report_test(6, "display off", start_err);

		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- tb_touch_adc_model.sv
`timescale 1ns/1ns

module tb_touch_adc_model (
	input  logic        touch_csb,
	input  logic        touch_clk,
	input  logic        touch_data_in,
	output logic        touch_data_out,
	output logic        touch_busy,
	// results handed back per command, and busy length in serial clocks
	input  logic [11:0] z_val,
	input  logic [11:0] x_val,
	input  logic [11:0] y_val,
	input  logic [3:0]  busy_clocks
);
	import touch_pkg::*;

	logic [7:0] cmd = '0;
	logic [11:0] shift_reg = '0;
	logic [11:0] value = '0;
	logic [3:0] busy_left = '0;
	int rise_cnt = 0;

	initial begin
		touch_data_out = 1'b0;
		touch_busy = 1'b0;
	end

	// result picked by the command byte
	function automatic logic [11:0] result_for(input logic [7:0] c);
		case (c)
		CMD_Z1: return z_val;
		CMD_X: return x_val;
		CMD_Y: return y_val;
		default: return 12'h000;
		endcase
	endfunction

	// command in on rising edges, busy and data out on falling edges
	always @(posedge touch_clk or negedge touch_clk or posedge touch_csb) begin
		if (touch_csb) begin
			rise_cnt <= 0;
			touch_busy <= 1'b0;
			touch_data_out <= 1'b0;
		end else if (touch_clk) begin
			if (rise_cnt < 8)
				cmd <= {cmd[6:0], touch_data_in};
			rise_cnt <= rise_cnt + 1;
		end else if (rise_cnt == 9) begin
			// acquisition clock done, msb goes out now
			value = result_for(cmd);
			touch_data_out <= value[11];
			shift_reg <= {value[10:0], 1'b0};
			busy_left <= busy_clocks;
			touch_busy <= (busy_clocks != 4'd0);
		end else if (rise_cnt > 9) begin
			if (touch_busy) begin
				busy_left <= busy_left - 1'b1;
				if (busy_left == 4'd1)
					touch_busy <= 1'b0;
			end else begin
				// previous rise took a bit, present the next one
				touch_data_out <= shift_reg[11];
				shift_reg <= {shift_reg[10:0], 1'b0};
			end
		end
	end

endmodule

//--- touch_display_top.sv
`timescale 1ns/1ns
`include "display_defs.svh"

module touch_display_top #(
	parameter int H_ACTIVE = `H_ACTIVE_DEF,
	parameter int H_BLANK = `H_BLANK_DEF,
	parameter int V_ACTIVE = `V_ACTIVE_DEF,
	parameter int V_BLANK = `V_BLANK_DEF,
	parameter int PIX_DIV = `PIX_DIV_DEF
) (
	input  logic        cclk,
	input  logic        rst_n,
	// host register port
	input  logic [7:0]  s_awaddr, s_araddr,
	input  logic        s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready,
	output logic        s_awready, s_wready, s_bvalid, s_arready, s_rvalid,
	input  logic [31:0] s_wdata,
	input  logic [3:0]  s_wstrb,
	output logic [1:0]  s_bresp, s_rresp,
	output logic [31:0] s_rdata,
	// touch adc pins
	input  logic        touch_busy, touch_data_out,
	output logic        touch_csb, touch_clk, touch_data_in,
	// tft panel pins
	output logic        tft_backlight, tft_display, tft_vdd, tft_data_ena,
	output logic [7:0]  tft_red, tft_green, tft_blue
);
	import touch_pkg::*;

	adc_cmd_e conv_cmd;
	logic conv_start, conv_done, new_frame, pix_en, data_ena, disp_en;
	logic [11:0] conv_data;
	logic [9:0] x, cursor_x;
	logic [8:0] y, cursor_y;
	logic [23:0] bg_color, cursor_color;

	touch_ctrl touch_ctrl_inst (
		.cclk, .rst_n,
		.s_awaddr, .s_araddr, .s_awvalid, .s_wvalid, .s_bready, .s_arvalid, .s_rready,
		.s_awready, .s_wready, .s_bvalid, .s_arready, .s_rvalid,
		.s_wdata, .s_wstrb, .s_bresp, .s_rresp, .s_rdata,
		.conv_start, .conv_cmd, .conv_done, .conv_data, .new_frame,
		.disp_en, .cursor_x, .cursor_y, .bg_color, .cursor_color
	);

	touch_spi touch_spi_inst (
		.cclk, .rst_n, .conv_start, .conv_cmd, .conv_done, .conv_data,
		.touch_csb, .touch_clk, .touch_data_in, .touch_data_out, .touch_busy
	);

	tft_timing #(
		.H_ACTIVE(H_ACTIVE), .H_BLANK(H_BLANK),
		.V_ACTIVE(V_ACTIVE), .V_BLANK(V_BLANK), .PIX_DIV(PIX_DIV)
	) tft_timing_inst (
		.cclk, .rst_n, .disp_en, .pix_en, .new_frame, .data_ena, .x, .y,
		.tft_backlight, .tft_display, .tft_vdd
	);

	cursor_render cursor_render_inst (
		.cclk, .rst_n, .pix_en, .x, .cursor_x, .y, .cursor_y,
		.bg_color, .cursor_color, .red(tft_red), .green(tft_green), .blue(tft_blue)
	);

	// same pixel stage as the renderer so enable lines up with rgb
	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n)
			tft_data_ena <= 1'b0;
		else if (pix_en)
			tft_data_ena <= data_ena;
	end

endmodule

//--- cursor_render.sv
`timescale 1ns/1ns

module cursor_render (
	input  logic        cclk,
	input  logic        rst_n,
	input  logic        pix_en,
	input  logic [9:0]  x,
	input  logic [9:0]  cursor_x,
	input  logic [8:0]  y,
	input  logic [8:0]  cursor_y,
	input  logic [23:0] bg_color,
	input  logic [23:0] cursor_color,
	output logic [7:0]  red,
	output logic [7:0]  green,
	output logic [7:0]  blue
);
	logic on_cursor;

	// crosshair is the full cursor row plus the full cursor column
	assign on_cursor = (x == cursor_x) || (y == cursor_y);

	// one pixel stage, red in the top byte
	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n) begin
			{red, green, blue} <= '0;
		end else if (pix_en) begin
			if (on_cursor)
				{red, green, blue} <= cursor_color;
			else
				{red, green, blue} <= bg_color;
		end
	end

endmodule

//--- tft_timing.sv
`timescale 1ns/1ns
`include "display_defs.svh"

module tft_timing #(
	parameter int H_ACTIVE = `H_ACTIVE_DEF,
	parameter int H_BLANK = `H_BLANK_DEF,
	parameter int V_ACTIVE = `V_ACTIVE_DEF,
	parameter int V_BLANK = `V_BLANK_DEF,
	parameter int PIX_DIV = `PIX_DIV_DEF
) (
	input  logic       cclk,
	input  logic       rst_n,
	input  logic       disp_en,
	output logic       pix_en,
	output logic       new_frame,
	output logic       data_ena,
	output logic [9:0] x,
	output logic [8:0] y,
	output logic       tft_backlight,
	output logic       tft_display,
	output logic       tft_vdd
);
	localparam int H_TOTAL = H_ACTIVE + H_BLANK;
	localparam int V_TOTAL = V_ACTIVE + V_BLANK;
	localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(PIX_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic [9:0] x_next;
	logic [8:0] y_next;

	// raster step, line wrap then frame wrap
	always_comb begin
		x_next = x + 1'b1;
		y_next = y;
		if (x == 10'(H_TOTAL - 1)) begin
			x_next = '0;
			y_next = (y == 9'(V_TOTAL - 1)) ? '0 : y + 1'b1;
		end
	end

	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			pix_en <= 1'b0;
			new_frame <= 1'b0;
			data_ena <= 1'b0;
			x <= '0;
			y <= '0;
			{tft_backlight, tft_display, tft_vdd} <= 3'b000;
		end else begin
			// pixel rate enable from cclk
			pix_en <= (div_cnt == DIV_LAST);
			div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
			new_frame <= 1'b0;
			// panel power pins follow the enable bit
			{tft_backlight, tft_display, tft_vdd} <= {3{disp_en}};
			if (pix_en) begin
				x <= x_next;
				y <= y_next;
				data_ena <= disp_en && x_next < 10'(H_ACTIVE) && y_next < 9'(V_ACTIVE);
				// single cclk pulse at the (0,0) wrap
				new_frame <= (x_next == '0) && (y_next == '0);
			end
		end
	end

endmodule

//--- touch_spi.sv
`timescale 1ns/1ns
`include "display_defs.svh"

module touch_spi #(
	parameter int SPI_DIV = `SPI_DIV_DEF
) (
	input  logic                cclk,
	input  logic                rst_n,
	input  logic                conv_start,
	input  touch_pkg::adc_cmd_e conv_cmd,
	output logic                conv_done,
	output logic [11:0]         conv_data,
	output logic                touch_csb,
	output logic                touch_clk,
	output logic                touch_data_in,
	input  logic                touch_data_out,
	input  logic                touch_busy
);
	import touch_pkg::*;

	localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_DIV - 1);

	spi_state_e state;
	logic [DIV_W-1:0] div_cnt;
	logic [7:0] cmd_sr;
	logic [11:0] data_sr;
	logic [4:0] bit_cnt;
	logic tick, rise, fall;

	// half period done, next edge of touch_clk
	assign tick = (div_cnt == DIV_LAST);
	assign rise = tick && !touch_clk;
	assign fall = tick && touch_clk;
	// command msb sits on the pin, shifts to zero when spent
	assign touch_data_in = cmd_sr[7];

	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SPI_IDLE;
			div_cnt <= '0;
			touch_clk <= 1'b0;
			touch_csb <= 1'b1;
			cmd_sr <= '0;
			bit_cnt <= '0;
			conv_done <= 1'b0;
		end else begin
			conv_done <= 1'b0;
			// serial clock only in cmd, busy and data
			if (state == SPI_IDLE || state == SPI_DONE) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
				if (tick)
					touch_clk <= !touch_clk;
			end
			case (state)
			SPI_IDLE: begin
				if (conv_start) begin
					touch_csb <= 1'b0;
					cmd_sr <= conv_cmd;
					bit_cnt <= '0;
					state <= SPI_CMD;
				end
			end
			SPI_CMD: begin
				// 8 command bits, next bit out on each falling edge
				if (fall) begin
					cmd_sr <= {cmd_sr[6:0], 1'b0};
					bit_cnt <= (bit_cnt == 5'd7) ? '0 : bit_cnt + 1'b1;
					if (bit_cnt == 5'd7)
						state <= SPI_BUSY;
				end
			end
			SPI_BUSY: begin
				// one clock for the adc to acquire
				if (fall)
					state <= SPI_DATA;
			end
			SPI_DATA: begin
				// 12 result bits, then 4 trailing clocks
				if (rise && !touch_busy)
					bit_cnt <= bit_cnt + 1'b1;
				if (fall && bit_cnt == 5'd16)
					state <= SPI_DONE;
			end
			SPI_DONE: begin
				touch_csb <= 1'b1;
				conv_done <= 1'b1;
				state <= SPI_IDLE;
			end
			default: state <= SPI_IDLE;
			endcase
		end
	end

	// result bits, msb first on rising edges once busy drops
	always_ff @(posedge cclk) begin
		if (state == SPI_DATA && rise && !touch_busy && bit_cnt < 5'd12)
			data_sr <= {data_sr[10:0], touch_data_out};
		if (state == SPI_DONE)
			conv_data <= data_sr;
	end

	// chip select held through the whole transaction
	assert property (@(posedge cclk) disable iff (!rst_n)
		(state != SPI_IDLE) |-> !touch_csb);

endmodule

//--- touch_ctrl.sv
`timescale 1ns/1ns
`include "display_defs.svh"

module touch_ctrl (
	input  logic                cclk,
	input  logic                rst_n,
	// axi4-lite slave
	input  logic [7:0]          s_awaddr, s_araddr,
	input  logic                s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready,
	output logic                s_awready, s_wready, s_bvalid, s_arready, s_rvalid,
	input  logic [31:0]         s_wdata,
	input  logic [3:0]          s_wstrb,
	output logic [1:0]          s_bresp, s_rresp,
	output logic [31:0]         s_rdata,
	// conversion link to the serial engine
	output logic                conv_start,
	output touch_pkg::adc_cmd_e conv_cmd,
	input  logic                conv_done,
	input  logic [11:0]         conv_data,
	input  logic                new_frame,
	// display settings
	output logic                disp_en,
	output logic [9:0]          cursor_x,
	output logic [8:0]          cursor_y,
	output logic [23:0]         bg_color, cursor_color
);
	import tft_pkg::*;
	import touch_pkg::*;

	ctl_state_e state;
	logic touch_en, pen_down;
	logic [11:0] z_min, x_raw;
	logic [7:0] frame_cnt;

	// byte lanes of wdata over the current value
	function automatic logic [31:0] merge(input logic [31:0] cur);
		for (int i = 0; i < 4; i++)
			if (s_wstrb[i])
				cur[8*i +: 8] = s_wdata[8*i +: 8];
		return cur;
	endfunction

	// write path, aw and w taken together
	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n) begin
			s_awready <= 1'b0;
			s_wready <= 1'b0;
			s_bvalid <= 1'b0;
			s_bresp <= OKAY;
			{touch_en, disp_en} <= 2'b00;
			bg_color <= '0;
			cursor_color <= '0;
			z_min <= '0;
		end else begin
			s_awready <= 1'b0;
			s_wready <= 1'b0;
			if (s_bvalid && s_bready)
				s_bvalid <= 1'b0;
			// no new write while a response waits
			if (s_awvalid && s_wvalid && !s_bvalid && !s_awready) begin
				s_awready <= 1'b1;
				s_wready <= 1'b1;
			end
			if (s_awready && s_awvalid && s_wvalid) begin
				s_bvalid <= 1'b1;
				s_bresp <= OKAY;
				case (s_awaddr)
				`REG_CTRL: {touch_en, disp_en} <= 2'(merge({30'b0, touch_en, disp_en}));
				`REG_BG: bg_color <= 24'(merge({8'b0, bg_color}));
				`REG_CURSOR_COLOR: cursor_color <= 24'(merge({8'b0, cursor_color}));
				`REG_Z_MIN: z_min <= 12'(merge({20'b0, z_min}));
				// touch, status and holes
				default: s_bresp <= SLVERR;
				endcase
			end
		end
	end

	// read path, one outstanding read
	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n) begin
			s_arready <= 1'b0;
			s_rvalid <= 1'b0;
			s_rresp <= OKAY;
			s_rdata <= '0;
		end else begin
			s_arready <= 1'b0;
			if (s_rvalid && s_rready)
				s_rvalid <= 1'b0;
			if (s_arvalid && !s_arready && !s_rvalid)
				s_arready <= 1'b1;
			if (s_arready && s_arvalid) begin
				s_rvalid <= 1'b1;
				s_rresp <= OKAY;
				case (s_araddr)
				`REG_CTRL: s_rdata <= {30'b0, touch_en, disp_en};
				`REG_BG: s_rdata <= {8'b0, bg_color};
				`REG_CURSOR_COLOR: s_rdata <= {8'b0, cursor_color};
				`REG_Z_MIN: s_rdata <= {20'b0, z_min};
				`REG_TOUCH: s_rdata <= {7'b0, cursor_y, 6'b0, cursor_x};
				`REG_STATUS: s_rdata <= {16'b0, frame_cnt, 6'b0, state != IDLE, pen_down};
				default: begin
					s_rdata <= '0;
					s_rresp <= SLVERR;
				end
				endcase
			end
		end
	end

	// sampling sequencer, z1 then x then y
	always_ff @(posedge cclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			conv_start <= 1'b0;
			conv_cmd <= CMD_Z1;
			x_raw <= '0;
			cursor_x <= '0;
			cursor_y <= '0;
			pen_down <= 1'b0;
			frame_cnt <= '0;
		end else begin
			conv_start <= 1'b0;
			if (new_frame)
				frame_cnt <= frame_cnt + 1'b1;
			case (state)
			IDLE: begin
				// one sample set per frame
				if (new_frame && touch_en) begin
					state <= CONV_Z;
					conv_start <= 1'b1;
					conv_cmd <= CMD_Z1;
				end
			end
			CONV_Z: begin
				if (conv_done && conv_data < z_min) begin
					// too light, old coordinates stay
					pen_down <= 1'b0;
					state <= IDLE;
				end else if (conv_done) begin
					state <= CONV_X;
					conv_start <= 1'b1;
					conv_cmd <= CMD_X;
				end
			end
			CONV_X: begin
				if (conv_done) begin
					x_raw <= conv_data;
					state <= CONV_Y;
					conv_start <= 1'b1;
					conv_cmd <= CMD_Y;
				end
			end
			CONV_Y: begin
				if (conv_done)
					state <= LATCH;
			end
			LATCH: begin
				// y result still held on conv_data
				cursor_x <= 10'(x_raw >> `TOUCH_SHIFT);
				cursor_y <= 9'(conv_data >> `TOUCH_SHIFT);
				pen_down <= 1'b1;
				state <= IDLE;
			end
			default: state <= IDLE;
			endcase
		end
	end

	// starts only come with a sequencer step
	assert property (@(posedge cclk) disable iff (!rst_n)
		conv_start |-> (state != $past(state)));
	// b response held until the host takes it
	assert property (@(posedge cclk) disable iff (!rst_n)
		s_bvalid && !s_bready |=> s_bvalid);

endmodule

//--- touch_pkg.sv
package touch_pkg;

	// adc control byte, start bit in the msb
	// z1 pressure, then x and y positions
	typedef enum logic [7:0] {
		CMD_Z1 = 8'hB0,
		CMD_X = 8'hD0,
		CMD_Y = 8'h90
	} adc_cmd_e;

	// serial engine states
	typedef enum logic [2:0] {
		SPI_IDLE,
		SPI_CMD,
		SPI_BUSY,
		SPI_DATA,
		SPI_DONE
	} spi_state_e;

endpackage

//--- tft_pkg.sv
package tft_pkg;

	// per-frame touch sampling sequence
	typedef enum logic [2:0] {
		IDLE,
		CONV_Z,
		CONV_X,
		CONV_Y,
		LATCH
	} ctl_state_e;

	// axi4-lite response codes in use
	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

endpackage

//--- display_defs.svh
`ifndef DISPLAY_DEFS_SVH
`define DISPLAY_DEFS_SVH

// default panel geometry, pixels and lines
`define H_ACTIVE_DEF 480
`define H_BLANK_DEF 45
`define V_ACTIVE_DEF 272
`define V_BLANK_DEF 16
// cclk cycles per pixel
`define PIX_DIV_DEF 11
// cclk cycles per half period of touch_clk
`define SPI_DIV_DEF 25
// 12-bit adc value down to pixel units
`define TOUCH_SHIFT 4
// register byte offsets on the host port
`define REG_CTRL 8'h00
`define REG_BG 8'h04
`define REG_CURSOR_COLOR 8'h08
`define REG_Z_MIN 8'h0C
`define REG_TOUCH 8'h10
`define REG_STATUS 8'h14

`endif
